//--- flist.f
common/pit_pkg.sv
logic/pit_pin_sampler.sv
logic/pit_control_word.sv
logic/pit_preset_register.sv
counter/pit_down_counter.sv
counter/pit_output_fsm.sv
logic/pit_readback.sv
logic/pit_counter_top.sv
test/pit_tb_clock.sv
test/pit_counter_tb.sv

//--- Bender.yml
package:
  name: pit_counter

sources:
  - common/pit_pkg.sv
  - logic/pit_pin_sampler.sv
  - logic/pit_control_word.sv
  - logic/pit_preset_register.sv
  - counter/pit_down_counter.sv
  - counter/pit_output_fsm.sv
  - logic/pit_readback.sv
  - logic/pit_counter_top.sv
  - target: test
    files:
      - test/pit_tb_clock.sv
      - test/pit_counter_tb.sv

//--- test/pit_counter_tb.sv
// Timer channel testbench with directed tests, check task, watchdog and summary
`timescale 1ns/1ns

module pit_counter_tb;

    localparam int SYNC_STAGES   = 2;
    localparam int CLOCK_NS      = 8;
    localparam int PERIOD_CLOCKS = 16;
    localparam int SETTLE_MARGIN = 8;
    // Upper bound on counter periods over all tests
    localparam int TOTAL_PERIODS = 112;
    localparam int WATCHDOG_NS   = TOTAL_PERIODS * PERIOD_CLOCKS * CLOCK_NS * 2;

    logic       clock;
    logic       reset;
    logic [7:0] data_in;
    logic       write_control;
    logic       write_counter;
    logic       read_counter;
    logic [7:0] read_data;
    logic       counter_clock;
    logic       counter_gate;
    logic       counter_out;

    integer seed;
    int     error_count;
    int     check_count;
    int     tests_run;
    int     tests_failed;

    pit_tb_clock #(
        .PERIOD_NS   (CLOCK_NS),
        .RESET_CYCLES(16)
    ) i_pit_tb_clock (
        .clock(clock),
        .reset(reset)
    );

    pit_counter_top #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i_pit_counter_top (
        .clock        (clock),
        .reset        (reset),
        .data_in      (data_in),
        .write_control(write_control),
        .write_counter(write_counter),
        .read_counter (read_counter),
        .read_data    (read_data),
        .counter_clock(counter_clock),
        .counter_gate (counter_gate),
        .counter_out  (counter_out)
    );

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) next_cycle();
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string message);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, message, actual, expected);
        end
    endtask

    function automatic int random_range(input int low, input int high);
        return low + ($unsigned($random(seed)) % (high - low + 1));
    endfunction

    task automatic write_control_word(input logic [7:0] value);
        data_in       = value;
        write_control = 1'b1;
        next_cycle();
        write_control = 1'b0;
        next_cycle();
    endtask

    task automatic write_preset_byte(input logic [7:0] value);
        data_in       = value;
        write_counter = 1'b1;
        next_cycle();
        write_counter = 1'b0;
        next_cycle();
    endtask

    task automatic write_preset(input logic [15:0] value);
        write_preset_byte(value[7:0]);
        write_preset_byte(value[15:8]);
    endtask

    // Byte is sampled while the read strobe is high and consumed on its fall
    task automatic read_byte(output logic [7:0] value);
        read_counter = 1'b1;
        next_cycle();
        value        = read_data;
        read_counter = 1'b0;
        wait_cycles(2);
    endtask

    // Low half with the falling edge comes first
    task automatic counter_period();
        counter_clock = 1'b0;
        wait_cycles(PERIOD_CLOCKS / 2);
        counter_clock = 1'b1;
        wait_cycles(PERIOD_CLOCKS / 2);
    endtask

    task automatic counter_periods(input int count);
        repeat (count) counter_period();
    endtask

    task automatic set_gate(input logic level);
        counter_gate = level;
        wait_cycles(SYNC_STAGES + 1 + SETTLE_MARGIN);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("[%0t ns] %s: PASS", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t ns] %s: FAIL, %0d errors", $time, name, error_count - errors_before);
        end
    endtask

    task automatic reset_and_mode0();
        int errors_before;
        int preset;
        errors_before = error_count;
        check_value(counter_out, 0, "counter_out after reset");
        check_value(read_data, 0, "read_data after reset");
        preset = random_range(2, 20);
        write_control_word(8'h30);
        write_preset(preset[15:0]);
        for (int i = 1; i <= preset; i++) begin
            counter_period();
            check_value(counter_out, 0, $sformatf("mode 0 out low after period %0d", i));
        end
        counter_period();
        check_value(counter_out, 1, $sformatf("mode 0 out high after %0d periods", preset + 1));
        report_test("reset_and_mode0", errors_before);
    endtask

    task automatic gate_hold_mode0();
        int errors_before;
        int preset;
        int hold;
        errors_before = error_count;
        preset = random_range(2, 20);
        hold   = random_range(1, 4);
        write_control_word(8'h30);
        write_preset(preset[15:0]);
        counter_periods(2);
        check_value(counter_out, 0, "out low before gate hold");
        set_gate(1'b0);
        for (int i = 0; i < hold; i++) begin
            counter_period();
            check_value(counter_out, 0, "out low while gate is low");
        end
        set_gate(1'b1);
        for (int i = 0; i < preset - 2; i++) begin
            counter_period();
            check_value(counter_out, 0, "out low after gate release");
        end
        counter_period();
        check_value(counter_out, 1, $sformatf("out high after hold of %0d periods", hold));
        report_test("gate_hold_mode0", errors_before);
    endtask

    task automatic latch_readback();
        int         errors_before;
        int         preset;
        int         elapsed;
        int         expected;
        logic [7:0] value;
        errors_before = error_count;
        preset   = random_range(256, 1255);
        elapsed  = random_range(1, 5);
        expected = preset + 1 - elapsed;
        write_control_word(8'h30);
        write_preset(preset[15:0]);
        counter_periods(elapsed);
        write_control_word(8'h00);
        // Later periods must not disturb the latched copy
        counter_periods(3);
        read_byte(value);
        check_value(value, expected[7:0], "latched count LSB");
        read_byte(value);
        check_value(value, expected[15:8], "latched count MSB");
        report_test("latch_readback", errors_before);
    endtask

    task automatic rate_generator_mode2();
        int   errors_before;
        int   preset;
        logic expected_out;
        errors_before = error_count;
        preset = random_range(3, 8);
        write_control_word(8'h34);
        write_preset(preset[15:0]);
        counter_periods(preset);
        for (int i = preset + 1; i <= 3 * preset; i++) begin
            counter_period();
            expected_out = ((i % preset) != 0);
            check_value(counter_out, expected_out, $sformatf("mode 2 out at period %0d", i));
        end
        // Output sits in its low pulse here
        set_gate(1'b0);
        check_value(counter_out, 1, "low gate forces mode 2 out high");
        set_gate(1'b1);
        report_test("rate_generator_mode2", errors_before);
    endtask

    task automatic square_wave_mode3();
        int   errors_before;
        int   half;
        int   preset;
        int   first;
        logic expected_out;
        errors_before = error_count;
        half   = random_range(2, 5);
        preset = 2 * half;
        first  = 0;
        write_control_word(8'h36);
        write_preset(preset[15:0]);
        // Mode 3 idles high and its first toggle goes low
        check_value(counter_out, 1, "mode 3 out high before counting");
        for (int i = 1; i <= 3 * preset; i++) begin
            counter_period();
            if (first == 0) begin
                if (counter_out === 1'b0) begin
                    first = i;
                end
            end else begin
                expected_out = ((((i - first) / half) % 2) != 0);
                check_value(counter_out, expected_out, $sformatf("mode 3 out at period %0d", i));
            end
        end
        if (first == 0) begin
            error_count++;
            $display("Mode 3 output never toggled within %0d counter periods", 3 * preset);
        end
        report_test("square_wave_mode3", errors_before);
    endtask

    task automatic bcd_count();
        int         errors_before;
        logic [7:0] value;
        errors_before = error_count;
        write_control_word(8'h31);
        write_preset(16'h0010);
        counter_periods(4);
        write_control_word(8'h00);
        read_byte(value);
        check_value(value, 8'h07, "BCD latched LSB");
        read_byte(value);
        check_value(value, 8'h00, "BCD latched MSB");
        report_test("bcd_count", errors_before);
    endtask

    initial begin
        seed          = 32'ha2c0;
        error_count   = 0;
        check_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        data_in       = 8'h00;
        write_control = 1'b0;
        write_counter = 1'b0;
        read_counter  = 1'b0;
        counter_clock = 1'b1;
        counter_gate  = 1'b1;
        @(negedge reset);
        next_cycle();
        reset_and_mode0();
        gate_hold_mode0();
        latch_readback();
        rate_generator_mode2();
        square_wave_mode3();
        bcd_count();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- test/pit_tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/1ns

module pit_tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

//--- logic/pit_counter_top.sv
// Timer channel top level connecting sampler, control, preset, counter, output and readback
`timescale 1ns/1ns

module pit_counter_top #(
    parameter int SYNC_STAGES = pit_pkg::SYNC_STAGES_DEFAULT
) (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       write_control,
    input  logic       write_counter,
    input  logic       read_counter,
    output logic [7:0] read_data,
    input  logic       counter_clock,
    input  logic       counter_gate,
    output logic       counter_out
);

    logic             count_edge;
    logic             gate_edge;
    logic             gate_level;
    pit_pkg::rw_sel_t rw_sel;
    pit_pkg::mode_t   mode;
    logic             bcd;
    logic             config_write;
    logic             latch_cmd;
    pit_pkg::count_t  load_value;
    logic             counting;
    logic             load_pending;
    logic             write_high_byte;
    pit_pkg::count_t  count;
    logic             terminal;
    logic             next_is_one;

    pit_pin_sampler #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i_pit_pin_sampler (
        .clock        (clock),
        .reset        (reset),
        .counter_clock(counter_clock),
        .counter_gate (counter_gate),
        .count_edge   (count_edge),
        .gate_edge    (gate_edge),
        .gate_level   (gate_level)
    );

    pit_control_word i_pit_control_word (
        .clock        (clock),
        .reset        (reset),
        .data_in      (data_in),
        .write_control(write_control),
        .rw_sel       (rw_sel),
        .mode         (mode),
        .bcd          (bcd),
        .config_write (config_write),
        .latch_cmd    (latch_cmd)
    );

    pit_preset_register i_pit_preset_register (
        .clock          (clock),
        .reset          (reset),
        .data_in        (data_in),
        .write_counter  (write_counter),
        .count_edge     (count_edge),
        .rw_sel         (rw_sel),
        .mode           (mode),
        .config_write   (config_write),
        .load_value     (load_value),
        .counting       (counting),
        .load_pending   (load_pending),
        .write_high_byte(write_high_byte)
    );

    pit_down_counter i_pit_down_counter (
        .clock       (clock),
        .reset       (reset),
        .count_edge  (count_edge),
        .gate_edge   (gate_edge),
        .gate_level  (gate_level),
        .counting    (counting),
        .load_pending(load_pending),
        .load_value  (load_value),
        .mode        (mode),
        .bcd         (bcd),
        .counter_out (counter_out),
        .count       (count),
        .terminal    (terminal),
        .next_is_one (next_is_one)
    );

    pit_output_fsm i_pit_output_fsm (
        .clock      (clock),
        .reset      (reset),
        .count_edge (count_edge),
        .gate_level (gate_level),
        .counting   (counting),
        .mode       (mode),
        .terminal   (terminal),
        .next_is_one(next_is_one),
        .counter_out(counter_out)
    );

    pit_readback i_pit_readback (
        .clock       (clock),
        .reset       (reset),
        .read_counter(read_counter),
        .latch_cmd   (latch_cmd),
        .config_write(config_write),
        .rw_sel      (rw_sel),
        .count       (count),
        .read_data   (read_data)
    );

endmodule

//--- logic/pit_readback.sv
// Count latch and byte-wise readback stepping
`timescale 1ns/1ns

module pit_readback (
    input  logic             clock,
    input  logic             reset,
    input  logic             read_counter,
    input  logic             latch_cmd,
    input  logic             config_write,
    input  pit_pkg::rw_sel_t rw_sel,
    input  pit_pkg::count_t  count,
    output logic [7:0]       read_data
);

    pit_pkg::count_t latched;
    logic            held;
    logic            read_prev;
    logic            read_fall;
    logic            read_high_byte;
    logic            two_byte;

    assign two_byte  = (rw_sel == pit_pkg::RW_LSB_MSB);
    assign read_fall = read_prev & ~read_counter;

    always_ff @(posedge clock) begin
        if (!held) begin
            latched <= count;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            read_prev <= 1'b0;
        end else begin
            read_prev <= read_counter;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || config_write) begin
            read_high_byte <= 1'b0;
        end else if (read_fall && two_byte) begin
            read_high_byte <= ~read_high_byte;
        end
    end

    // Released once the last byte of the format has been taken
    always_ff @(posedge clock) begin
        if (reset) begin
            held <= 1'b0;
        end else if (latch_cmd) begin
            held <= 1'b1;
        end else if (held && read_fall && (!two_byte || read_high_byte)) begin
            held <= 1'b0;
        end
    end

    always_comb begin
        if (rw_sel == pit_pkg::RW_MSB || (two_byte && read_high_byte)) begin
            read_data = latched[15:8];
        end else begin
            read_data = latched[7:0];
        end
    end

endmodule

//--- counter/pit_output_fsm.sv
// Output state machine for modes 0, 2 and 3
`timescale 1ns/1ns

module pit_output_fsm (
    input  logic           clock,
    input  logic           reset,
    input  logic           count_edge,
    input  logic           gate_level,
    input  logic           counting,
    input  pit_pkg::mode_t mode,
    input  logic           terminal,
    input  logic           next_is_one,
    output logic           counter_out
);

    typedef enum logic [1:0] {
        IDLE,
        COUNTING_LOW,
        COUNTING_HIGH,
        PULSE_LOW
    } state_t;

    state_t state;
    state_t state_next;
    state_t current;

    always_comb begin
        // Idle behaves as the mode's starting level
        if (state != IDLE) begin
            current = state;
        end else if (mode == pit_pkg::MODE_0) begin
            current = COUNTING_LOW;
        end else begin
            current = COUNTING_HIGH;
        end

        state_next = current;
        if (!counting) begin
            state_next = IDLE;
        end else begin
            case (mode)
                pit_pkg::MODE_0: begin
                    if (count_edge && terminal) begin
                        state_next = COUNTING_HIGH;
                    end
                end
                pit_pkg::MODE_2: begin
                    if (!gate_level) begin
                        state_next = COUNTING_HIGH;
                    end else if (count_edge) begin
                        state_next = next_is_one ? PULSE_LOW : COUNTING_HIGH;
                    end
                end
                default: begin
                    if (!gate_level) begin
                        state_next = COUNTING_HIGH;
                    end else if (count_edge && terminal) begin
                        state_next = (current == COUNTING_HIGH) ? COUNTING_LOW : COUNTING_HIGH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign counter_out = (state == COUNTING_HIGH) ||
                         ((state == IDLE) && (mode != pit_pkg::MODE_0));

    a_mode0_no_fall : assert property (
        @(posedge clock) disable iff (reset)
        (counting && $past(counting) && mode == pit_pkg::MODE_0) |-> !$fell(counter_out)
    );

endmodule

//--- counter/pit_down_counter.sv
// Count register with binary and BCD decrement, reload rules and terminal count flags
`timescale 1ns/1ns

module pit_down_counter (
    input  logic             clock,
    input  logic             reset,
    input  logic             count_edge,
    input  logic             gate_edge,
    input  logic             gate_level,
    input  logic             counting,
    input  logic             load_pending,
    input  pit_pkg::count_t  load_value,
    input  pit_pkg::mode_t   mode,
    input  logic             bcd,
    input  logic             counter_out,
    output pit_pkg::count_t  count,
    output logic             terminal,
    output logic             next_is_one
);

    pit_pkg::count_t dec1;
    pit_pkg::count_t dec2;
    pit_pkg::count_t step;
    pit_pkg::count_t stepped;
    pit_pkg::count_t count_next;
    logic            wrap;

    // One step down, zero stays at zero
    function automatic pit_pkg::count_t dec_one(input pit_pkg::count_t value,
                                                input logic is_bcd);
        pit_pkg::count_t result;
        logic            borrow;
        result = value;
        borrow = 1'b1;
        if (value == '0) begin
            result = '0;
        end else if (!is_bcd) begin
            result = value - 1'b1;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (borrow) begin
                    if (value[4*i +: 4] == 4'd0) begin
                        result[4*i +: 4] = pit_pkg::BCD_DIGIT_MAX;
                    end else begin
                        result[4*i +: 4] = value[4*i +: 4] - 4'd1;
                        borrow = 1'b0;
                    end
                end
            end
            result[pit_pkg::COUNT_W] = value[pit_pkg::COUNT_W] & ~borrow;
        end
        return result;
    endfunction

    assign dec1 = dec_one(count, bcd);
    assign dec2 = dec_one(dec1, bcd);

    always_comb begin
        // Mode 3 counts by two; an odd load spends one extra step in the high half
        if (mode != pit_pkg::MODE_3) begin
            step = dec1;
        end else if (!count[0]) begin
            step = dec2;
        end else if (counter_out) begin
            step = dec1;
        end else begin
            step = {dec2[pit_pkg::COUNT_W:1], 1'b0};
        end

        stepped = gate_level ? step : count;
        wrap    = (stepped == '0);

        if (mode == pit_pkg::MODE_0) begin
            count_next = load_pending ? load_value : stepped;
            terminal   = (count_next == '0);
        end else begin
            count_next = (wrap || gate_edge) ? load_value : stepped;
            terminal   = wrap;
        end
        next_is_one = (count_next == pit_pkg::count_t'(1));
    end

    always_ff @(posedge clock) begin
        if (reset || !counting) begin
            count <= '0;
        end else if (count_edge) begin
            count <= count_next;
        end
    end

    a_bcd_digits : assert property (
        @(posedge clock) disable iff (reset)
        (bcd && counting && count_edge) |=>
            (count[3:0] <= pit_pkg::BCD_DIGIT_MAX) &&
            (count[7:4] <= pit_pkg::BCD_DIGIT_MAX) &&
            (count[11:8] <= pit_pkg::BCD_DIGIT_MAX) &&
            (count[15:12] <= pit_pkg::BCD_DIGIT_MAX)
    );

endmodule

//--- logic/pit_preset_register.sv
// Preset byte assembly, load value with full-range flag, and counting start control
`timescale 1ns/1ns

module pit_preset_register (
    input  logic              clock,
    input  logic              reset,
    input  logic [7:0]        data_in,
    input  logic              write_counter,
    input  logic              count_edge,
    input  pit_pkg::rw_sel_t  rw_sel,
    input  pit_pkg::mode_t    mode,
    input  logic              config_write,
    output pit_pkg::count_t   load_value,
    output logic              counting,
    output logic              load_pending,
    output logic              write_high_byte
);

    logic [pit_pkg::COUNT_W-1:0] preset;
    logic [pit_pkg::COUNT_W-1:0] preset_used;
    logic                        two_byte;
    logic                        to_high;

    assign two_byte = (rw_sel == pit_pkg::RW_LSB_MSB);
    assign to_high  = (rw_sel == pit_pkg::RW_MSB) || (two_byte && write_high_byte);

    always_ff @(posedge clock) begin
        if (write_counter) begin
            if (to_high) begin
                preset[15:8] <= data_in;
            end else begin
                preset[7:0] <= data_in;
            end
        end
    end

    // Byte step, set while the MSB of a two-byte preset is due
    always_ff @(posedge clock) begin
        if (reset || config_write) begin
            write_high_byte <= 1'b0;
        end else if (write_counter && two_byte) begin
            write_high_byte <= ~write_high_byte;
        end
    end

    always_comb begin
        case (rw_sel)
            pit_pkg::RW_MSB: preset_used = {preset[15:8], 8'h00};
            pit_pkg::RW_LSB: preset_used = {8'h00, preset[7:0]};
            default:         preset_used = preset;
        endcase
        load_value = {(preset_used == '0), preset_used};
    end

    always_ff @(posedge clock) begin
        if (reset || config_write) begin
            counting <= 1'b0;
        end else if (write_counter) begin
            if (!two_byte || write_high_byte) begin
                counting <= 1'b1;
            end else if (mode == pit_pkg::MODE_0) begin
                // First byte of a new mode 0 preset halts the count
                counting <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else if (write_counter) begin
            load_pending <= 1'b1;
        end else if (count_edge) begin
            load_pending <= 1'b0;
        end
    end

endmodule

//--- logic/pit_control_word.sv
// Control word decoder for read/load select, mode, BCD flag and the counter latch command
`timescale 1ns/1ns

module pit_control_word (
    input  logic             clock,
    input  logic             reset,
    input  logic [7:0]       data_in,
    input  logic             write_control,
    output pit_pkg::rw_sel_t rw_sel,
    output pit_pkg::mode_t   mode,
    output logic             bcd,
    output logic             config_write,
    output logic             latch_cmd
);

    logic is_latch;

    assign is_latch     = (data_in[5:4] == pit_pkg::RW_LATCH);
    assign config_write = write_control & ~is_latch;
    assign latch_cmd    = write_control & is_latch;

    always_ff @(posedge clock) begin
        if (reset) begin
            rw_sel <= pit_pkg::RW_MSB;
            bcd    <= 1'b0;
        end else if (config_write) begin
            rw_sel <= pit_pkg::rw_sel_t'(data_in[5:4]);
            bcd    <= data_in[0];
        end
    end

    // Modes 6 and 7 alias 2 and 3, modes 1, 4 and 5 are not taken
    always_ff @(posedge clock) begin
        if (reset) begin
            mode <= pit_pkg::MODE_0;
        end else if (config_write) begin
            case (data_in[3:1])
                3'd0: begin
                    mode <= pit_pkg::MODE_0;
                end
                3'd2, 3'd6: begin
                    mode <= pit_pkg::MODE_2;
                end
                3'd3, 3'd7: begin
                    mode <= pit_pkg::MODE_3;
                end
                default: begin
                    mode <= mode;
                end
            endcase
        end
    end

endmodule

//--- logic/pit_pin_sampler.sv
// Counter clock and gate synchronizers with counter clock fall and gate rise detection
`timescale 1ns/1ns

module pit_pin_sampler #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic counter_clock,
    input  logic counter_gate,
    output logic count_edge,
    output logic gate_edge,
    output logic gate_level
);

    logic [SYNC_STAGES-1:0] clock_sync;
    logic [SYNC_STAGES-1:0] gate_sync;
    logic                   clock_prev;
    logic                   gate_prev;

    always_ff @(posedge clock) begin
        if (reset) begin
            clock_sync <= '0;
            gate_sync  <= '0;
            clock_prev <= 1'b0;
        end else begin
            clock_sync <= {clock_sync[SYNC_STAGES-2:0], counter_clock};
            gate_sync  <= {gate_sync[SYNC_STAGES-2:0], counter_gate};
            clock_prev <= clock_sync[SYNC_STAGES-1];
        end
    end

    // Gate sample follows a drop at once, a rise only at a count edge
    always_ff @(posedge clock) begin
        if (reset) begin
            gate_prev <= 1'b0;
        end else if (count_edge || gate_prev) begin
            gate_prev <= gate_sync[SYNC_STAGES-1];
        end
    end

    assign gate_level = gate_sync[SYNC_STAGES-1];
    assign count_edge = clock_prev & ~clock_sync[SYNC_STAGES-1];
    assign gate_edge  = count_edge & gate_level & ~gate_prev;

    a_count_edge_single : assert property (
        @(posedge clock) disable iff (reset) count_edge |=> !count_edge
    );

endmodule

//--- common/pit_pkg.sv
// Shared count width, count type, read/load select and mode encodings, BCD digit limit
package pit_pkg;

    // Width of the preset and count registers
    localparam int COUNT_W = 16;

    // Top bit marks a loaded zero as the full range
    typedef logic [COUNT_W:0] count_t;

    // Read/load select field, control word bits 5:4
    typedef enum logic [1:0] {
        RW_LATCH   = 2'b00,
        RW_LSB     = 2'b01,
        RW_MSB     = 2'b10,
        RW_LSB_MSB = 2'b11
    } rw_sel_t;

    // Supported operating modes, control word bits 3:1
    typedef enum logic [2:0] {
        MODE_0 = 3'd0,
        MODE_2 = 3'd2,
        MODE_3 = 3'd3
    } mode_t;

    localparam logic [3:0] BCD_DIGIT_MAX = 4'd9;

    // Pin synchronizer depth
    localparam int SYNC_STAGES_DEFAULT = 2;

endpackage
